// ==== include/lc4_params.svh ====
`ifndef LC4_PARAMS_SVH
`define LC4_PARAMS_SVH

// datapath and address width
`define LC4_WORD 16
// register file size and select width
`define LC4_NREGS 8
`define LC4_RSEL 3
// boot address of the program counter
`define LC4_RESET_PC 16'h8200

// major opcodes, insn[15:12]
`define LC4_OP_BR 4'b0000
`define LC4_OP_ARITH 4'b0001
`define LC4_OP_AND 4'b0101
`define LC4_OP_LDR 4'b0110
`define LC4_OP_STR 4'b0111
`define LC4_OP_CONST 4'b1001

// arith sub-codes, insn[5:3]
`define LC4_SUB_ADD 3'b000
`define LC4_SUB_SUB 3'b010

// retire slot stall codes
`define LC4_STALL_NONE 2'd0
`define LC4_STALL_PIPE 2'd1
`define LC4_STALL_BRANCH 2'd2

`endif

// ==== verilog/lc4_pkg.sv ====
`default_nettype none

`include "lc4_params.svh"

package lc4_pkg;

   // register form: ADD, SUB, AND
   typedef struct packed {
      logic [3:0]           opcode;
      logic [`LC4_RSEL-1:0] rd;
      logic [`LC4_RSEL-1:0] rs;
      logic [2:0]           sub;
      logic [`LC4_RSEL-1:0] rt;
   } insn_reg_t;

   // memory form: LDR, STR (rd is the source of a store)
   typedef struct packed {
      logic [3:0]           opcode;
      logic [`LC4_RSEL-1:0] rd;
      logic [`LC4_RSEL-1:0] rs;
      logic [5:0]           offset;
   } insn_mem_t;

   // branch form: BR uses nzp, CONST uses the same bits as rd
   typedef struct packed {
      logic [3:0] opcode;
      logic [2:0] nzp;
      logic [8:0] imm9;
   } insn_br_t;

   // one instruction word, three decodings
   typedef union packed {
      insn_reg_t r;
      insn_mem_t m;
      insn_br_t  b;
   } insn_t;

   // fetch to decode slot
   typedef struct packed {
      logic                 valid;
      logic [1:0]           stall;
      logic [`LC4_WORD-1:0] pc;
      insn_t                insn;
   } fd_t;

   // decode to execute slot
   typedef struct packed {
      logic                 valid;
      logic [1:0]           stall;
      logic [`LC4_WORD-1:0] pc;
      insn_t                insn;
      logic [`LC4_WORD-1:0] rs_data;
      logic [`LC4_WORD-1:0] rt_data;
      logic                 regfile_we;
      logic                 nzp_we;
      logic                 is_load;
      logic                 is_store;
      logic                 is_branch;
   } dx_t;

   // execute to memory slot, result is alu value or memory address
   typedef struct packed {
      logic                 valid;
      logic [1:0]           stall;
      logic [`LC4_WORD-1:0] pc;
      insn_t                insn;
      logic [`LC4_WORD-1:0] result;
      logic [`LC4_WORD-1:0] store_data;
      logic [`LC4_RSEL-1:0] rd;
      logic                 regfile_we;
      logic                 nzp_we;
      logic                 is_load;
      logic                 is_store;
   } xm_t;

   // writeback bus to register file and nzp register
   typedef struct packed {
      logic                 regfile_we;
      logic [`LC4_RSEL-1:0] rd;
      logic [`LC4_WORD-1:0] data;
      logic                 nzp_we;
      logic [2:0]           nzp;
   } wb_t;

   typedef struct packed {
      logic                 taken;
      logic [`LC4_WORD-1:0] target;
   } redirect_t;

   typedef struct packed {
      logic                 we;
      logic [`LC4_WORD-1:0] addr;
      logic [`LC4_WORD-1:0] towrite;
   } dmem_req_t;

   // retire trace, one slot per cycle
   typedef struct packed {
      logic                 valid;
      logic [1:0]           stall;
      logic [`LC4_WORD-1:0] pc;
      insn_t                insn;
      logic                 regfile_we;
      logic [`LC4_RSEL-1:0] wsel;
      logic [`LC4_WORD-1:0] regfile_data;
      logic                 nzp_we;
      logic [2:0]           nzp_new_bits;
      logic                 dmem_we;
      logic [`LC4_WORD-1:0] dmem_addr;
      logic [`LC4_WORD-1:0] dmem_data;
   } trace_t;

endpackage

`default_nettype wire

// ==== verilog/lc4_fetch.sv ====
`default_nettype none

`include "lc4_params.svh"

module lc4_fetch
   import lc4_pkg::*;
(
   input  logic                 gwe,
   input  logic                 i_arst_n,
   input  redirect_t            i_redirect,
   input  insn_t                i_cur_insn,
   output logic [`LC4_WORD-1:0] o_cur_pc,
   output fd_t                  o_fd
);

   logic [`LC4_WORD-1:0] pc_q;
   logic [`LC4_WORD-1:0] pc_next;
   fd_t                  fd_q;

   // sequential fetch unless execute resolved a taken branch
   assign pc_next = i_redirect.taken ? i_redirect.target : pc_q + `LC4_WORD'(1);

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pc_q <= `LC4_RESET_PC;
      end else begin
         pc_q <= pc_next;
      end
   end

   // fetch to decode slot
   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         fd_q       <= '0;
         fd_q.stall <= `LC4_STALL_PIPE;
      end else if (i_redirect.taken) begin
         // word fetched this cycle is on the wrong path
         fd_q       <= '0;
         fd_q.stall <= `LC4_STALL_BRANCH;
      end else begin
         fd_q.valid <= 1'b1;
         fd_q.stall <= `LC4_STALL_NONE;
         fd_q.pc    <= pc_q;
         fd_q.insn  <= i_cur_insn;
      end
   end

   // instruction memory answers in the same cycle
   assign o_cur_pc = pc_q;
   assign o_fd     = fd_q;

endmodule

`default_nettype wire

// ==== verilog/lc4_regfile.sv ====
`default_nettype none

`include "lc4_params.svh"

module lc4_regfile
   import lc4_pkg::*;
(
   input  logic                 gwe,
   input  logic                 i_arst_n,
   input  logic [`LC4_RSEL-1:0] i_rs,
   input  logic [`LC4_RSEL-1:0] i_rt,
   output logic [`LC4_WORD-1:0] o_rs_data,
   output logic [`LC4_WORD-1:0] o_rt_data,
   input  wb_t                  i_wb
);

   logic [`LC4_WORD-1:0] regs_q [`LC4_NREGS];

   // single write port, fed from writeback
   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < `LC4_NREGS; i++) begin
            regs_q[i] <= '0;
         end
      end else if (i_wb.regfile_we) begin
         regs_q[i_wb.rd] <= i_wb.data;
      end
   end

   // reads see a write of the same cycle
   assign o_rs_data = (i_wb.regfile_we && i_wb.rd == i_rs) ? i_wb.data : regs_q[i_rs];
   assign o_rt_data = (i_wb.regfile_we && i_wb.rd == i_rt) ? i_wb.data : regs_q[i_rt];

endmodule

`default_nettype wire

// ==== verilog/lc4_decode.sv ====
`default_nettype none

`include "lc4_params.svh"

module lc4_decode
   import lc4_pkg::*;
(
   input  logic                 gwe,
   input  logic                 i_arst_n,
   input  fd_t                  i_fd,
   input  redirect_t            i_redirect,
   output logic [`LC4_RSEL-1:0] o_rs,
   output logic [`LC4_RSEL-1:0] o_rt,
   input  logic [`LC4_WORD-1:0] i_rs_data,
   input  logic [`LC4_WORD-1:0] i_rt_data,
   output dx_t                  o_dx
);

   logic regfile_we;
   logic nzp_we;
   logic is_load;
   logic is_store;
   logic is_branch;
   dx_t  dx_q;

   // control flags for the kept opcodes
   always_comb begin
      regfile_we = 1'b0;
      nzp_we     = 1'b0;
      is_load    = 1'b0;
      is_store   = 1'b0;
      is_branch  = 1'b0;
      case (i_fd.insn.r.opcode)
         `LC4_OP_BR: begin
            // nzp of 000 is a NOP, execute never takes it
            is_branch = 1'b1;
         end
         `LC4_OP_ARITH: begin
            // only add and sub, other sub-codes retire with no writes
            if (i_fd.insn.r.sub == `LC4_SUB_ADD || i_fd.insn.r.sub == `LC4_SUB_SUB) begin
               regfile_we = 1'b1;
               nzp_we     = 1'b1;
            end
         end
         `LC4_OP_AND, `LC4_OP_CONST: begin
            regfile_we = 1'b1;
            nzp_we     = 1'b1;
         end
         `LC4_OP_LDR: begin
            regfile_we = 1'b1;
            nzp_we     = 1'b1;
            is_load    = 1'b1;
         end
         `LC4_OP_STR: begin
            is_store = 1'b1;
         end
         default: begin
            // unknown opcode, nothing is written
            regfile_we = 1'b0;
         end
      endcase
   end

   // rs sits at [8:6] in every form
   assign o_rs = i_fd.insn.m.rs;
   // a store reads its data register from the rd field
   assign o_rt = is_store ? i_fd.insn.m.rd : i_fd.insn.r.rt;

   // decode to execute slot
   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         dx_q       <= '0;
         dx_q.stall <= `LC4_STALL_PIPE;
      end else if (i_redirect.taken) begin
         // younger than the branch in execute, squash it
         dx_q       <= '0;
         dx_q.stall <= `LC4_STALL_BRANCH;
      end else begin
         dx_q.valid      <= i_fd.valid;
         dx_q.stall      <= i_fd.stall;
         dx_q.pc         <= i_fd.pc;
         dx_q.insn       <= i_fd.insn;
         dx_q.rs_data    <= i_rs_data;
         dx_q.rt_data    <= i_rt_data;
         // bubbles carry no side effects
         dx_q.regfile_we <= regfile_we & i_fd.valid;
         dx_q.nzp_we     <= nzp_we & i_fd.valid;
         dx_q.is_load    <= is_load & i_fd.valid;
         dx_q.is_store   <= is_store & i_fd.valid;
         dx_q.is_branch  <= is_branch & i_fd.valid;
      end
   end

   assign o_dx = dx_q;

endmodule

`default_nettype wire

// ==== verilog/lc4_execute.sv ====
`default_nettype none

`include "lc4_params.svh"

module lc4_execute
   import lc4_pkg::*;
(
   input  logic      gwe,
   input  logic      i_arst_n,
   input  dx_t       i_dx,
   input  wb_t       i_wb,
   output redirect_t o_redirect,
   output xm_t       o_xm
);

   logic [`LC4_WORD-1:0] sext_off6;
   logic [`LC4_WORD-1:0] sext_imm9;
   logic [`LC4_WORD-1:0] alu_result;
   logic [2:0]           nzp_q;
   logic [2:0]           nzp_cur;
   logic                 br_taken;
   xm_t                  xm_q;

   // sign-extended immediates
   assign sext_off6 = {{(`LC4_WORD-6){i_dx.insn.m.offset[5]}}, i_dx.insn.m.offset};
   assign sext_imm9 = {{(`LC4_WORD-9){i_dx.insn.b.imm9[8]}}, i_dx.insn.b.imm9};

   // alu
   always_comb begin
      alu_result = '0;
      if (i_dx.is_load || i_dx.is_store) begin
         // effective address for ldr and str
         alu_result = i_dx.rs_data + sext_off6;
      end else begin
         case (i_dx.insn.r.opcode)
            `LC4_OP_ARITH: begin
               if (i_dx.insn.r.sub == `LC4_SUB_SUB) begin
                  alu_result = i_dx.rs_data - i_dx.rt_data;
               end else begin
                  alu_result = i_dx.rs_data + i_dx.rt_data;
               end
            end
            `LC4_OP_AND: begin
               alu_result = i_dx.rs_data & i_dx.rt_data;
            end
            `LC4_OP_CONST: begin
               alu_result = sext_imm9;
            end
            default: begin
               alu_result = '0;
            end
         endcase
      end
   end

   // nzp register, written from writeback
   // registers clear to zero on reset, so the flags start at z
   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         nzp_q <= 3'b010;
      end else if (i_wb.nzp_we) begin
         nzp_q <= i_wb.nzp;
      end
   end

   // a write in this cycle is visible to the branch test
   assign nzp_cur = i_wb.nzp_we ? i_wb.nzp : nzp_q;

   // any condition bit matching the flags takes the branch
   assign br_taken = i_dx.valid & i_dx.is_branch & (|(i_dx.insn.b.nzp & nzp_cur));

   // target is pc + 1 + imm9
   assign o_redirect.taken  = br_taken;
   assign o_redirect.target = i_dx.pc + `LC4_WORD'(1) + sext_imm9;

   // execute to memory slot
   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         xm_q       <= '0;
         xm_q.stall <= `LC4_STALL_PIPE;
      end else begin
         xm_q.valid      <= i_dx.valid;
         xm_q.stall      <= i_dx.stall;
         xm_q.pc         <= i_dx.pc;
         xm_q.insn       <= i_dx.insn;
         xm_q.result     <= alu_result;
         xm_q.store_data <= i_dx.rt_data;
         xm_q.rd         <= i_dx.insn.r.rd;
         xm_q.regfile_we <= i_dx.regfile_we;
         xm_q.nzp_we     <= i_dx.nzp_we;
         xm_q.is_load    <= i_dx.is_load;
         xm_q.is_store   <= i_dx.is_store;
      end
   end

   assign o_xm = xm_q;

endmodule

`default_nettype wire

// ==== verilog/lc4_memory.sv ====
`default_nettype none

`include "lc4_params.svh"

module lc4_memory
   import lc4_pkg::*;
(
   input  logic                 gwe,
   input  logic                 i_arst_n,
   input  xm_t                  i_xm,
   input  logic [`LC4_WORD-1:0] i_cur_dmem_data,
   output dmem_req_t            o_dmem,
   output wb_t                  o_wb,
   output trace_t               o_trace
);

   logic [`LC4_WORD-1:0] wdata;
   logic [2:0]           nzp_bits;
   logic [`LC4_WORD-1:0] dmem_data;
   trace_t               trace_q;

   // data memory port, address only for loads and stores
   assign o_dmem.we      = i_xm.is_store;
   assign o_dmem.addr    = (i_xm.is_load || i_xm.is_store) ? i_xm.result : '0;
   assign o_dmem.towrite = i_xm.store_data;

   // loads write the returned word, everything else the alu value
   assign wdata = i_xm.is_load ? i_cur_dmem_data : i_xm.result;

   // n, z or p of the written value
   always_comb begin
      if (wdata[`LC4_WORD-1]) begin
         nzp_bits = 3'b100;
      end else if (wdata == '0) begin
         nzp_bits = 3'b010;
      end else begin
         nzp_bits = 3'b001;
      end
   end

   // trace shows the word moved across the memory port
   assign dmem_data = i_xm.is_load  ? i_cur_dmem_data :
                      i_xm.is_store ? i_xm.store_data : '0;

   // writeback register, also the retire trace
   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         trace_q       <= '0;
         trace_q.stall <= `LC4_STALL_PIPE;
      end else begin
         trace_q.valid        <= i_xm.valid;
         trace_q.stall        <= i_xm.stall;
         trace_q.pc           <= i_xm.pc;
         trace_q.insn         <= i_xm.insn;
         trace_q.regfile_we   <= i_xm.regfile_we;
         trace_q.wsel         <= i_xm.rd;
         // zero when not written, keeps the trace deterministic
         trace_q.regfile_data <= i_xm.regfile_we ? wdata : '0;
         trace_q.nzp_we       <= i_xm.nzp_we;
         trace_q.nzp_new_bits <= i_xm.nzp_we ? nzp_bits : 3'b000;
         trace_q.dmem_we      <= o_dmem.we;
         trace_q.dmem_addr    <= o_dmem.addr;
         trace_q.dmem_data    <= dmem_data;
      end
   end

   assign o_trace = trace_q;

   // writeback bus straight from the retire register
   assign o_wb.regfile_we = trace_q.regfile_we;
   assign o_wb.rd         = trace_q.wsel;
   assign o_wb.data       = trace_q.regfile_data;
   assign o_wb.nzp_we     = trace_q.nzp_we;
   assign o_wb.nzp        = trace_q.nzp_new_bits;

endmodule

`default_nettype wire

// ==== verilog/lc4_pipe_top.sv ====
`default_nettype none

`include "lc4_params.svh"

module lc4_pipe_top
   import lc4_pkg::*;
(
   input  logic                 gwe,
   input  logic                 i_arst_n,
   output logic [`LC4_WORD-1:0] o_cur_pc,
   input  insn_t                i_cur_insn,
   output dmem_req_t            o_dmem,
   input  logic [`LC4_WORD-1:0] i_cur_dmem_data,
   output trace_t               o_trace
);

   fd_t                  fd;
   dx_t                  dx;
   xm_t                  xm;
   wb_t                  wb;
   redirect_t            redirect;
   logic [`LC4_RSEL-1:0] rs_sel;
   logic [`LC4_RSEL-1:0] rt_sel;
   logic [`LC4_WORD-1:0] rs_data;
   logic [`LC4_WORD-1:0] rt_data;

   lc4_fetch u_fetch (
      .gwe        (gwe),
      .i_arst_n   (i_arst_n),
      .i_redirect (redirect),
      .i_cur_insn (i_cur_insn),
      .o_cur_pc   (o_cur_pc),
      .o_fd       (fd)
   );

   // read ports from decode, write port from writeback
   lc4_regfile u_regfile (
      .gwe       (gwe),
      .i_arst_n  (i_arst_n),
      .i_rs      (rs_sel),
      .i_rt      (rt_sel),
      .o_rs_data (rs_data),
      .o_rt_data (rt_data),
      .i_wb      (wb)
   );

   lc4_decode u_decode (
      .gwe        (gwe),
      .i_arst_n   (i_arst_n),
      .i_fd       (fd),
      .i_redirect (redirect),
      .o_rs       (rs_sel),
      .o_rt       (rt_sel),
      .i_rs_data  (rs_data),
      .i_rt_data  (rt_data),
      .o_dx       (dx)
   );

   // redirect feeds fetch and decode in the same cycle
   lc4_execute u_execute (
      .gwe        (gwe),
      .i_arst_n   (i_arst_n),
      .i_dx       (dx),
      .i_wb       (wb),
      .o_redirect (redirect),
      .o_xm       (xm)
   );

   lc4_memory u_memory (
      .gwe             (gwe),
      .i_arst_n        (i_arst_n),
      .i_xm            (xm),
      .i_cur_dmem_data (i_cur_dmem_data),
      .o_dmem          (o_dmem),
      .o_wb            (wb),
      .o_trace         (o_trace)
   );

endmodule

`default_nettype wire

// ==== bench/lc4_pipe_checker.sv ====
`default_nettype none

`include "lc4_params.svh"

module lc4_pipe_checker
   import lc4_pkg::*;
(
   input logic      gwe,
   input logic      i_arst_n,
   input trace_t    i_trace,
   input dmem_req_t i_dmem
);

   // count of failed properties
   int assert_failures = 0;

   // a slot retires exactly when it carries no stall code
   a_valid_stall: assert property (@(posedge gwe) disable iff (!i_arst_n)
      i_trace.valid == (i_trace.stall == `LC4_STALL_NONE))
   else begin
      $error("trace valid %0b does not match stall code %0d", i_trace.valid, i_trace.stall);
      assert_failures++;
   end

   // a store on the port belongs to a real instruction and retires in the next slot
   a_store_traced: assert property (@(posedge gwe) disable iff (!i_arst_n)
      i_dmem.we |=> (i_trace.valid && i_trace.dmem_we))
   else begin
      $error("store on the data port not retired by a valid slot in the following cycle");
      assert_failures++;
   end

   // four stages to fill, nothing retires before that
   a_boot_quiet: assert property (@(posedge gwe)
      $rose(i_arst_n) |-> !i_trace.valid [*4])
   else begin
      $error("trace valid within four cycles of reset release");
      assert_failures++;
   end

endmodule

`default_nettype wire

// ==== bench/lc4_pipe_tb.sv ====
`default_nettype none

`include "lc4_params.svh"

module lc4_pipe_tb
   import lc4_pkg::*;
();

   localparam int TIMEOUT_CYCLES = 4000;
   localparam int RAND_GROUPS = 60;

   logic                 gwe;
   logic                 i_arst_n;
   logic [`LC4_WORD-1:0] o_cur_pc;
   insn_t                i_cur_insn;
   dmem_req_t            o_dmem;
   logic [`LC4_WORD-1:0] i_cur_dmem_data;
   trace_t               o_trace;

   // memories behind the dut, indexed by the low address byte
   insn_t                imem [256];
   logic [`LC4_WORD-1:0] dmem [256];
   int                   prog_len;
   logic [`LC4_WORD-1:0] stop_pc;

   // architectural state of the reference model
   logic [`LC4_WORD-1:0] ref_pc;
   logic [`LC4_WORD-1:0] ref_regs [`LC4_NREGS];
   logic [2:0]           ref_nzp;
   logic [`LC4_WORD-1:0] ref_dmem [256];
   logic                 ref_taken;

   logic [31:0] lfsr;

   // state of the comparing process
   int cycles;
   int bubbles_left;
   bit started;
   bit at_end;
   int taken_seen;
   int checks;
   int errors;

   lc4_pipe_top u_lc4_pipe_top (
      .gwe             (gwe),
      .i_arst_n        (i_arst_n),
      .o_cur_pc        (o_cur_pc),
      .i_cur_insn      (i_cur_insn),
      .o_dmem          (o_dmem),
      .i_cur_dmem_data (i_cur_dmem_data),
      .o_trace         (o_trace)
   );

   bind lc4_pipe_top lc4_pipe_checker u_checker (
      .gwe      (gwe),
      .i_arst_n (i_arst_n),
      .i_trace  (o_trace),
      .i_dmem   (o_dmem)
   );

   initial begin
      gwe = 1'b0;
      forever begin
         #4 gwe = ~gwe;
      end
   end

   // memories answer on the falling edge, stores land there too
   always @(negedge gwe) begin
      i_cur_insn      <= imem[o_cur_pc[7:0]];
      i_cur_dmem_data <= dmem[o_dmem.addr[7:0]];
      if (o_dmem.we) begin
         dmem[o_dmem.addr[7:0]] <= o_dmem.towrite;
      end
   end

   // galois lfsr, one step per bit
   function automatic logic lfsr_bit();
      logic out;
      out  = lfsr[0];
      lfsr = lfsr >> 1;
      if (out) begin
         lfsr = lfsr ^ 32'hd000_0001;
      end
      return out;
   endfunction

   function automatic logic [15:0] rand_bits(int n);
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[14:0], lfsr_bit()};
      end
      return v;
   endfunction

   // instruction encoders
   function automatic insn_t enc_reg(logic [3:0] op, logic [2:0] rd, logic [2:0] rs,
                                     logic [2:0] sub, logic [2:0] rt);
      return {op, rd, rs, sub, rt};
   endfunction

   function automatic insn_t enc_mem(logic [3:0] op, logic [2:0] rd, logic [2:0] rs,
                                     logic [5:0] off);
      return {op, rd, rs, off};
   endfunction

   function automatic insn_t enc_br(logic [2:0] nzp, logic [8:0] imm);
      return {`LC4_OP_BR, nzp, imm};
   endfunction

   function automatic insn_t enc_const(logic [2:0] rd, logic [8:0] imm);
      return {`LC4_OP_CONST, rd, imm};
   endfunction

   function automatic logic [2:0] nzp_of(logic [15:0] v);
      if (v[15]) begin
         return 3'b100;
      end else if (v == '0) begin
         return 3'b010;
      end
      return 3'b001;
   endfunction

   // isa model, executes one instruction and returns its retire slot
   function automatic trace_t ref_step();
      trace_t      t;
      insn_t       w;
      logic [15:0] sx9;
      logic [15:0] addr;
      logic [15:0] val;
      logic        wr;
      w    = imem[ref_pc[7:0]];
      sx9  = {{7{w.b.imm9[8]}}, w.b.imm9};
      addr = ref_regs[w.m.rs] + {{10{w.m.offset[5]}}, w.m.offset};
      val  = '0;
      wr   = 1'b0;
      t    = '0;
      t.valid   = 1'b1;
      t.stall   = `LC4_STALL_NONE;
      t.pc      = ref_pc;
      t.insn    = w;
      ref_taken = 1'b0;
      case (w.r.opcode)
         `LC4_OP_BR: begin
            ref_taken = |(w.b.nzp & ref_nzp);
         end
         `LC4_OP_ARITH: begin
            // other sub-codes are not implemented and write nothing
            wr  = (w.r.sub == `LC4_SUB_ADD) || (w.r.sub == `LC4_SUB_SUB);
            val = (w.r.sub == `LC4_SUB_SUB) ? ref_regs[w.r.rs] - ref_regs[w.r.rt] :
                                              ref_regs[w.r.rs] + ref_regs[w.r.rt];
         end
         `LC4_OP_AND: begin
            wr  = 1'b1;
            val = ref_regs[w.r.rs] & ref_regs[w.r.rt];
         end
         `LC4_OP_CONST: begin
            wr  = 1'b1;
            val = sx9;
         end
         `LC4_OP_LDR: begin
            wr          = 1'b1;
            val         = ref_dmem[addr[7:0]];
            t.dmem_addr = addr;
            t.dmem_data = val;
         end
         `LC4_OP_STR: begin
            ref_dmem[addr[7:0]] = ref_regs[w.m.rd];
            t.dmem_we           = 1'b1;
            t.dmem_addr         = addr;
            t.dmem_data         = ref_regs[w.m.rd];
         end
         default: begin
            // anything else retires with no state change
            wr = 1'b0;
         end
      endcase
      if (wr) begin
         t.regfile_we     = 1'b1;
         t.wsel           = w.r.rd;
         t.regfile_data   = val;
         t.nzp_we         = 1'b1;
         t.nzp_new_bits   = nzp_of(val);
         ref_regs[w.r.rd] = val;
         ref_nzp          = nzp_of(val);
      end
      ref_pc = ref_taken ? ref_pc + 16'd1 + sx9 : ref_pc + 16'd1;
      return t;
   endfunction

   task automatic report_error(string msg);
      $display("** Error @ %0t: %s", $time, msg);
      errors++;
   endtask

   task automatic compare_slot();
      trace_t e;
      bit     mem_op;
      e      = ref_step();
      mem_op = (e.insn.r.opcode == `LC4_OP_LDR) || (e.insn.r.opcode == `LC4_OP_STR);
      checks++;
      assert (o_trace.pc == e.pc && o_trace.insn == e.insn) else
         report_error($sformatf("retired pc %h insn %h, expected pc %h insn %h",
                                o_trace.pc, o_trace.insn, e.pc, e.insn));
      assert (o_trace.regfile_we == e.regfile_we && (!e.regfile_we ||
              (o_trace.wsel == e.wsel && o_trace.regfile_data == e.regfile_data))) else
         report_error($sformatf("pc %h wrote r%0d=%h (we %0b), expected r%0d=%h (we %0b)",
                                e.pc, o_trace.wsel, o_trace.regfile_data, o_trace.regfile_we,
                                e.wsel, e.regfile_data, e.regfile_we));
      assert (o_trace.nzp_we == e.nzp_we &&
              (!e.nzp_we || o_trace.nzp_new_bits == e.nzp_new_bits)) else
         report_error($sformatf("pc %h nzp %b (we %0b), expected %b (we %0b)", e.pc,
                                o_trace.nzp_new_bits, o_trace.nzp_we, e.nzp_new_bits, e.nzp_we));
      assert (o_trace.dmem_we == e.dmem_we && o_trace.dmem_data == e.dmem_data &&
              (!mem_op || o_trace.dmem_addr == e.dmem_addr)) else
         report_error($sformatf("pc %h dmem we %0b [%h]=%h, expected we %0b [%h]=%h", e.pc,
                                o_trace.dmem_we, o_trace.dmem_addr, o_trace.dmem_data,
                                e.dmem_we, e.dmem_addr, e.dmem_data));
      if (ref_taken) begin
         bubbles_left = 2;
         taken_seen++;
      end
      if (e.pc == stop_pc) begin
         at_end = 1'b1;
      end
   endtask

   // compares every retire slot, sampled away from the rising edge
   always @(negedge gwe) begin
      if (!i_arst_n) begin
         cycles       = 0;
         bubbles_left = 0;
         started      = 1'b0;
         at_end       = 1'b0;
      end else begin
         cycles++;
         if (bubbles_left > 0) begin
            checks++;
            assert (!o_trace.valid && o_trace.stall == `LC4_STALL_BRANCH) else
               report_error($sformatf("slot after taken branch: valid %0b stall %0d",
                                      o_trace.valid, o_trace.stall));
            bubbles_left--;
         end else if (!started && !o_trace.valid) begin
            // pipeline still filling
            checks++;
            assert (o_trace.stall == `LC4_STALL_PIPE && cycles != 4) else
               report_error($sformatf("cycle %0d after reset: stall %0d, no boot retirement",
                                      cycles, o_trace.stall));
         end else begin
            if (!started) begin
               checks++;
               assert (cycles == 4 && o_trace.pc == `LC4_RESET_PC) else
                  report_error($sformatf("first retirement pc %h after %0d cycles",
                                         o_trace.pc, cycles));
               started = 1'b1;
            end
            assert (o_trace.valid) else
               report_error($sformatf("bubble with stall %0d where pc %h should retire",
                                      o_trace.stall, ref_pc));
            if (o_trace.valid) begin
               compare_slot();
            end
         end
      end
   end

   // one instruction and the three nops that cover the pipeline depth
   task automatic emit(insn_t w);
      imem[prog_len]     = w;
      imem[prog_len + 1] = 16'h0000;
      imem[prog_len + 2] = 16'h0000;
      imem[prog_len + 3] = 16'h0000;
      prog_len += 4;
   endtask

   task automatic prog_alu();
      emit(enc_const(3'd1, 9'd5));
      emit(enc_const(3'd2, 9'h1fd));
      emit(enc_reg(`LC4_OP_ARITH, 3'd3, 3'd1, `LC4_SUB_ADD, 3'd2));
      emit(enc_reg(`LC4_OP_ARITH, 3'd4, 3'd2, `LC4_SUB_SUB, 3'd1));
      emit(enc_reg(`LC4_OP_AND, 3'd5, 3'd1, 3'b000, 3'd2));
      emit(enc_reg(`LC4_OP_ARITH, 3'd6, 3'd1, `LC4_SUB_SUB, 3'd1));
      emit(enc_reg(`LC4_OP_ARITH, 3'd7, 3'd4, `LC4_SUB_ADD, 3'd4));
      emit(enc_reg(`LC4_OP_AND, 3'd0, 3'd6, 3'b000, 3'd1));
   endtask

   task automatic prog_mem();
      emit(enc_const(3'd1, 9'd10));
      emit(enc_const(3'd2, 9'd123));
      emit(enc_mem(`LC4_OP_STR, 3'd2, 3'd1, 6'd3));
      emit(enc_const(3'd2, 9'd0));
      emit(enc_mem(`LC4_OP_LDR, 3'd3, 3'd1, 6'd3));
      emit(enc_const(3'd4, 9'h19c));
      emit(enc_mem(`LC4_OP_STR, 3'd4, 3'd1, 6'h3e));
      emit(enc_mem(`LC4_OP_LDR, 3'd5, 3'd1, 6'h3e));
      // untouched word, returns the fill pattern
      emit(enc_mem(`LC4_OP_LDR, 3'd6, 3'd1, 6'd20));
   endtask

   task automatic prog_taken();
      emit(enc_const(3'd1, 9'd1));
      emit(enc_br(3'b001, 9'd7));
      emit(enc_const(3'd7, 9'h055));
      emit(enc_const(3'd2, 9'd2));
      emit(enc_const(3'd3, 9'h1f0));
      emit(enc_br(3'b111, 9'd7));
      emit(enc_const(3'd7, 9'h0aa));
      // taken onto the very next group
      emit(enc_br(3'b100, 9'd3));
      emit(enc_const(3'd4, 9'd4));
   endtask

   task automatic prog_not_taken();
      emit(enc_const(3'd1, 9'h1fe));
      emit(enc_br(3'b011, 9'd7));
      emit(enc_const(3'd2, 9'd9));
      emit(enc_br(3'b000, 9'h0ff));
      emit(enc_const(3'd3, 9'd0));
      emit(enc_br(3'b101, 9'd7));
      emit(enc_const(3'd4, 9'd4));
   endtask

   task automatic prog_random();
      logic [2:0] kind;
      logic [2:0] rd;
      logic [2:0] rs;
      logic [2:0] rt;
      int         skip;
      for (int g = 0; g < RAND_GROUPS; g++) begin
         kind = 3'(rand_bits(3));
         rd   = 3'(rand_bits(3));
         rs   = 3'(rand_bits(3));
         rt   = 3'(rand_bits(3));
         case (kind)
            3'd1: emit(enc_reg(`LC4_OP_ARITH, rd, rs, `LC4_SUB_ADD, rt));
            3'd2: emit(enc_reg(`LC4_OP_ARITH, rd, rs, `LC4_SUB_SUB, rt));
            3'd3: emit(enc_reg(`LC4_OP_AND, rd, rs, 3'b000, rt));
            3'd4: emit(enc_mem(`LC4_OP_LDR, rd, rs, 6'(rand_bits(6))));
            3'd5: emit(enc_mem(`LC4_OP_STR, rd, rs, 6'(rand_bits(6))));
            3'd6: begin
               // forward only, never past the end of the program
               skip = int'(rand_bits(2));
               if (skip > RAND_GROUPS - 1 - g) begin
                  skip = RAND_GROUPS - 1 - g;
               end
               emit(enc_br(rd, 9'(4 * (skip + 1) - 1)));
            end
            default: emit(enc_const(rd, 9'(rand_bits(9))));
         endcase
      end
   endtask

   task automatic run_test(int id, string name, int min_taken, int max_taken);
      int err0;
      int chk0;
      int wait_cycles;
      err0 = errors;
      chk0 = checks;
      @(negedge gwe);
      i_arst_n <= 1'b0;
      @(negedge gwe);
      // pipeline held, memories and model reloaded
      for (int i = 0; i < 256; i++) begin
         imem[i]     = 16'(i);
         dmem[i]     = {8'(i) ^ 8'hc3, 8'(i)};
         ref_dmem[i] = dmem[i];
      end
      for (int r = 0; r < `LC4_NREGS; r++) begin
         ref_regs[r] = '0;
      end
      // zeroed registers read as z
      ref_nzp    = 3'b010;
      ref_pc     = `LC4_RESET_PC;
      taken_seen = 0;
      prog_len   = 0;
      case (id)
         1: begin
            emit(enc_const(3'd1, 9'd1));
            emit(enc_const(3'd2, 9'h100));
         end
         2: prog_alu();
         3: prog_mem();
         4: prog_taken();
         5: prog_not_taken();
         default: prog_random();
      endcase
      stop_pc = `LC4_RESET_PC + 16'(prog_len);
      repeat (7) @(negedge gwe);
      assert (o_cur_pc == `LC4_RESET_PC && !o_trace.valid && !o_dmem.we) else
         report_error($sformatf("in reset: pc %h trace valid %0b dmem we %0b",
                                o_cur_pc, o_trace.valid, o_dmem.we));
      i_arst_n <= 1'b1;
      wait_cycles = 0;
      while (!at_end && wait_cycles < TIMEOUT_CYCLES) begin
         @(posedge gwe);
         wait_cycles++;
      end
      if (!at_end) begin
         $display("test %s timed out: pc %h never retired within %0d cycles",
                  name, stop_pc, TIMEOUT_CYCLES);
         errors++;
      end
      if (taken_seen < min_taken || taken_seen > max_taken) begin
         $display("test %s ran %0d taken branches, outside %0d to %0d",
                  name, taken_seen, min_taken, max_taken);
         errors++;
      end
      // stores that went through the port must match the model
      for (int i = 0; i < 256; i++) begin
         assert (dmem[i] == ref_dmem[i]) else
            report_error($sformatf("data word %h is %h, expected %h", i, dmem[i], ref_dmem[i]));
      end
      if (errors == err0) begin
         $display("test %s: pass, %0d checks", name, checks - chk0);
      end else begin
         $display("test %s: fail, %0d errors", name, errors - err0);
      end
   endtask

   initial begin
      int failures;
      i_arst_n        = 1'b0;
      i_cur_insn      = '0;
      i_cur_dmem_data = '0;
      lfsr            = 32'h52d;
      errors          = 0;
      checks          = 0;
      stop_pc         = '0;
      run_test(1, "reset", 0, 0);
      run_test(2, "alu", 0, 0);
      run_test(3, "load_store", 0, 0);
      run_test(4, "branch_taken", 3, 3);
      run_test(5, "branch_not_taken", 0, 0);
      run_test(6, "random_program", 1, RAND_GROUPS);
      failures = u_lc4_pipe_top.u_checker.assert_failures;
      $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, failures);
      if (errors == 0 && failures == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== lc4_pipe.f ====
+incdir+include
verilog/lc4_pkg.sv
verilog/lc4_fetch.sv
verilog/lc4_regfile.sv
verilog/lc4_decode.sv
verilog/lc4_execute.sv
verilog/lc4_memory.sv
verilog/lc4_pipe_top.sv
bench/lc4_pipe_checker.sv
bench/lc4_pipe_tb.sv

// ==== Bender.yml ====
package:
  name: lc4_pipe

sources:
  - include_dirs:
      - include
    files:
      - verilog/lc4_pkg.sv
      - verilog/lc4_fetch.sv
      - verilog/lc4_regfile.sv
      - verilog/lc4_decode.sv
      - verilog/lc4_execute.sv
      - verilog/lc4_memory.sv
      - verilog/lc4_pipe_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - bench/lc4_pipe_checker.sv
      - bench/lc4_pipe_tb.sv
